// File: Bender.yml
package:
  name: decode

export_include_dirs:
  - include

sources:
  - files:
      - logic/decodePkg.sv
      - logic/fieldStage.sv
      - logic/classStage.sv
      - logic/uopStage.sv
      - logic/decodeTop.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/decodeTb.sv

// File: bench/decodeTb.sv
`timescale 1ns/1ps
`include "decode_macros.svh"

module decodeTb;
    import decodePkg::*;

    typedef struct packed {
        microOp_t prim;
        microOp_t sec;
    } uopPair_t;

    localparam int resetCycles   = 16;
    localparam int directedCount = 52;
    localparam int randomCount   = 2000;
    localparam int drainCycles   = 8;
    // Stimulus length plus roughly a fifth of headroom.
    localparam int cycleLimit = resetCycles + directedCount + randomCount + drainCycles + 424;

    localparam logic [26*6-1:0] specialFuncts = {
        `FUNCT_ADD, `FUNCT_ADDU, `FUNCT_SUB, `FUNCT_SUBU, `FUNCT_SLT, `FUNCT_SLTU,
        `FUNCT_AND, `FUNCT_OR, `FUNCT_XOR, `FUNCT_NOR, `FUNCT_SLL, `FUNCT_SLLV,
        `FUNCT_SRA, `FUNCT_SRAV, `FUNCT_SRL, `FUNCT_SRLV, `FUNCT_JR, `FUNCT_JALR,
        `FUNCT_MFHI, `FUNCT_MFLO, `FUNCT_MTHI, `FUNCT_MTLO,
        `FUNCT_MULT, `FUNCT_MULTU, `FUNCT_DIV, `FUNCT_DIVU
    };
    localparam logic [4*5-1:0] regimmCodes = {`RT_BLTZ, `RT_BGEZ, `RT_BLTZAL, `RT_BGEZAL};
    // Load, store, coprocessor move, SYSCALL, BREAK, bad REGIMM rt, bad funct.
    localparam logic [7*32-1:0] illegalWords = {
        32'h8c43_0004, 32'hac43_0004, 32'h4080_6000, 32'h0000_000c,
        32'h0000_000d, 32'h0462_0010, 32'h0043_2001
    };

    logic         clk;
    logic         reset;
    fetchBundle_t fetch;
    microOp_t     uopPrimary;
    microOp_t     uopSecondary;

    integer   seed;
    int       cycleCount = 0;
    int       errorCount = 0;
    int       checkCount = 0;
    uopPair_t expQ[$];
    int       stampQ[$];

    decodeTop u_dut (
        .clk          (clk),
        .reset        (reset),
        .fetch        (fetch),
        .uopPrimary   (uopPrimary),
        .uopSecondary (uopSecondary)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    function automatic uopCode_t decodeCode(input instWord_t w);
        if (w.raw == '0)
            return UOP_NONE;
        case (w.rFmt.opcode)
            `OPC_SPECIAL: begin
                case (w.rFmt.funct)
                    `FUNCT_ADD:   return UOP_ADD;
                    `FUNCT_ADDU:  return UOP_ADDU;
                    `FUNCT_SUB:   return UOP_SUB;
                    `FUNCT_SUBU:  return UOP_SUBU;
                    `FUNCT_SLT:   return UOP_SLT;
                    `FUNCT_SLTU:  return UOP_SLTU;
                    `FUNCT_AND:   return UOP_AND;
                    `FUNCT_OR:    return UOP_OR;
                    `FUNCT_XOR:   return UOP_XOR;
                    `FUNCT_NOR:   return UOP_NOR;
                    `FUNCT_SLL:   return UOP_SLL;
                    `FUNCT_SLLV:  return UOP_SLLV;
                    `FUNCT_SRA:   return UOP_SRA;
                    `FUNCT_SRAV:  return UOP_SRAV;
                    `FUNCT_SRL:   return UOP_SRL;
                    `FUNCT_SRLV:  return UOP_SRLV;
                    `FUNCT_JR:    return UOP_JR;
                    `FUNCT_JALR:  return UOP_JALR;
                    `FUNCT_MFHI:  return UOP_MFHI;
                    `FUNCT_MFLO:  return UOP_MFLO;
                    `FUNCT_MTHI:  return UOP_MTHI;
                    `FUNCT_MTLO:  return UOP_MTLO;
                    `FUNCT_MULT:  return UOP_MULTHI;
                    `FUNCT_MULTU: return UOP_MULTUHI;
                    `FUNCT_DIV:   return UOP_DIVHI;
                    `FUNCT_DIVU:  return UOP_DIVUHI;
                    default:      return UOP_NONE;
                endcase
            end
            `OPC_REGIMM: begin
                case (w.iFmt.rt)
                    `RT_BLTZ:   return UOP_BLTZ;
                    `RT_BGEZ:   return UOP_BGEZ;
                    `RT_BLTZAL: return UOP_BLTZAL;
                    `RT_BGEZAL: return UOP_BGEZAL;
                    default:    return UOP_NONE;
                endcase
            end
            `OPC_J:     return UOP_J;
            `OPC_JAL:   return UOP_JAL;
            `OPC_BEQ:   return UOP_BEQ;
            `OPC_BNE:   return UOP_BNE;
            `OPC_BLEZ:  return UOP_BLEZ;
            `OPC_BGTZ:  return UOP_BGTZ;
            `OPC_ADDI:  return UOP_ADDI;
            `OPC_ADDIU: return UOP_ADDIU;
            `OPC_SLTI:  return UOP_SLTI;
            `OPC_SLTIU: return UOP_SLTIU;
            `OPC_ANDI:  return UOP_ANDI;
            `OPC_ORI:   return UOP_ORI;
            `OPC_XORI:  return UOP_XORI;
            `OPC_LUI:   return UOP_LUI;
            default:    return UOP_NONE;
        endcase
    endfunction

    // Addresses of unused operands and of an unused destination stay zero.
    function automatic microOp_t withRegs(input microOp_t u,
                                          input logic r0, input logic [5:0] a0,
                                          input logic r1, input logic [5:0] a1,
                                          input logic wr, input logic [5:0] d);
        u.op0Read  = r0;
        u.op0Addr  = r0 ? a0 : 6'd0;
        u.op1Read  = r1;
        u.op1Addr  = r1 ? a1 : 6'd0;
        u.dstWrite = wr;
        u.dstAddr  = wr ? d : 6'd0;
        return u;
    endfunction

    function automatic uopPair_t expectUops(input fetchBundle_t fb);
        uopPair_t    e;
        uopCode_t    code;
        logic [5:0]  rs;
        logic [5:0]  rt;
        logic [5:0]  rd;
        logic [15:0] imm16;
        microOp_t    p;

        e     = '0;
        rs    = {1'b0, fb.inst.rFmt.rs};
        rt    = {1'b0, fb.inst.rFmt.rt};
        rd    = {1'b0, fb.inst.rFmt.rd};
        imm16 = fb.inst.iFmt.imm16;
        code  = fb.valid ? decodeCode(fb.inst) : UOP_NONE;
        e.prim.pc          = fb.pc;
        e.prim.isDelaySlot = fb.isDelaySlot;
        e.sec.pc           = fb.pc;
        e.sec.isDelaySlot  = fb.isDelaySlot;
        if (code == UOP_NONE)
            return e;

        p         = e.prim;
        p.valid   = 1'b1;
        p.uopCode = code;
        case (code)
            UOP_ADD, UOP_ADDU, UOP_SUB, UOP_SUBU, UOP_SLT, UOP_SLTU:
                p = withRegs(p, 1, rs, 1, rt, 1, rd);
            UOP_AND, UOP_OR, UOP_XOR, UOP_NOR: begin
                p = withRegs(p, 1, rs, 1, rt, 1, rd);
                p.aluType = ALU_LOGIC;
            end
            UOP_ADDI, UOP_ADDIU, UOP_SLTI, UOP_SLTIU: begin
                p = withRegs(p, 1, rs, 0, 0, 1, rt);
                p.imm = {{16{imm16[15]}}, imm16};
            end
            UOP_ANDI, UOP_ORI, UOP_XORI, UOP_LUI: begin
                p = withRegs(p, 1, rs, 0, 0, 1, rt);
                p.aluType = ALU_LOGIC;
                p.imm = (code == UOP_LUI) ? {imm16, 16'h0000} : {16'h0000, imm16};
            end
            UOP_SLL, UOP_SRA, UOP_SRL: begin
                p = withRegs(p, 1, rt, 0, 0, 1, rd);
                p.aluType = ALU_SHIFT;
                p.imm = {27'd0, fb.inst.rFmt.shamt};
            end
            UOP_SLLV, UOP_SRAV, UOP_SRLV: begin
                p = withRegs(p, 1, rt, 1, rs, 1, rd);
                p.aluType = ALU_SHIFT;
            end
            UOP_BEQ, UOP_BNE, UOP_BGEZ, UOP_BGTZ, UOP_BLEZ, UOP_BLTZ,
            UOP_BGEZAL, UOP_BLTZAL: begin
                if (code == UOP_BEQ || code == UOP_BNE)
                    p = withRegs(p, 1, rs, 1, rt, 0, 0);
                else
                    p = withRegs(p, 1, rs, 0, 0, code == UOP_BGEZAL || code == UOP_BLTZAL,
                                 `REG_LINK);
                p.aluType    = ALU_BRANCH;
                p.branchType = BR_COND;
                p.branchAddr = {{14{imm16[15]}}, imm16, 2'b00};
            end
            UOP_J, UOP_JAL: begin
                p = withRegs(p, 0, 0, 0, 0, code == UOP_JAL, `REG_LINK);
                p.aluType    = ALU_BRANCH;
                p.branchType = BR_JUMP;
                p.branchAddr = {fb.pc[31:28], fb.inst.jFmt.target26, 2'b00};
            end
            UOP_JR, UOP_JALR: begin
                p = withRegs(p, 1, rs, 0, 0, code == UOP_JALR, rd);
                p.aluType    = ALU_BRANCH;
                p.branchType = BR_JUMPREG;
            end
            UOP_MFHI, UOP_MFLO: begin
                p = withRegs(p, 1, (code == UOP_MFHI) ? `REG_HI : `REG_LO, 0, 0, 1, rd);
                p.aluType = ALU_MOVE;
            end
            UOP_MTHI, UOP_MTLO: begin
                p = withRegs(p, 1, rs, 0, 0, 1, (code == UOP_MTHI) ? `REG_HI : `REG_LO);
                p.aluType = ALU_MOVE;
            end
            default: begin
                // Multiply and divide put the HI half here and the LO half in the second uop.
                p = withRegs(p, 1, rs, 1, rt, 1, `REG_HI);
                p.unit = UNIT_MDU;
                e.sec = p;
                e.sec.dstAddr = `REG_LO;
                case (code)
                    UOP_MULTHI:  e.sec.uopCode = UOP_MULTLO;
                    UOP_MULTUHI: e.sec.uopCode = UOP_MULTULO;
                    UOP_DIVHI:   e.sec.uopCode = UOP_DIVLO;
                    default:     e.sec.uopCode = UOP_DIVULO;
                endcase
            end
        endcase
        e.prim = p;
        return e;
    endfunction

    task automatic checkValue(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("** Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compareUop(input string which, input microOp_t got, input microOp_t exp);
        checkValue({which, ".valid"}, 64'(got.valid), 64'(exp.valid));
        checkValue({which, ".uopCode"}, 64'(got.uopCode), 64'(exp.uopCode));
        checkValue({which, ".unit"}, 64'(got.unit), 64'(exp.unit));
        checkValue({which, ".aluType"}, 64'(got.aluType), 64'(exp.aluType));
        checkValue({which, ".op0Addr"}, 64'(got.op0Addr), 64'(exp.op0Addr));
        checkValue({which, ".op1Addr"}, 64'(got.op1Addr), 64'(exp.op1Addr));
        checkValue({which, ".dstAddr"}, 64'(got.dstAddr), 64'(exp.dstAddr));
        checkValue({which, ".op0Read"}, 64'(got.op0Read), 64'(exp.op0Read));
        checkValue({which, ".op1Read"}, 64'(got.op1Read), 64'(exp.op1Read));
        checkValue({which, ".dstWrite"}, 64'(got.dstWrite), 64'(exp.dstWrite));
        checkValue({which, ".imm"}, 64'(got.imm), 64'(exp.imm));
        checkValue({which, ".branchType"}, 64'(got.branchType), 64'(exp.branchType));
        checkValue({which, ".branchAddr"}, 64'(got.branchAddr), 64'(exp.branchAddr));
        checkValue({which, ".pc"}, 64'(got.pc), 64'(exp.pc));
        checkValue({which, ".isDelaySlot"}, 64'(got.isDelaySlot), 64'(exp.isDelaySlot));
    endtask

    // Outputs are sampled mid-cycle. An entry is due three edges after it was driven.
    always @(negedge clk) begin
        uopPair_t e;
        if (!reset) begin
            if (expQ.size() != 0 && cycleCount - stampQ[0] >= 3) begin
                e = expQ.pop_front();
                void'(stampQ.pop_front());
                compareUop("uopPrimary", uopPrimary, e.prim);
                compareUop("uopSecondary", uopSecondary, e.sec);
            end else begin
                checkValue("uopPrimary.valid (idle)", 64'(uopPrimary.valid), 64'd0);
                checkValue("uopSecondary.valid (idle)", 64'(uopSecondary.valid), 64'd0);
            end
        end
    end

    function automatic fetchBundle_t makeFetch(input logic valid, input logic [31:0] word,
                                               input logic [31:0] pc, input logic ds);
        fetchBundle_t fb;
        fb.valid       = valid;
        fb.inst.raw    = word;
        fb.pc          = pc;
        fb.isDelaySlot = ds;
        return fb;
    endfunction

    // Called just after a rising edge; returns just after the next one.
    task automatic driveFetch(input fetchBundle_t fb);
        fetch = fb;
        expQ.push_back(expectUops(fb));
        stampQ.push_back(cycleCount);
        @(posedge clk);
        #2;
    endtask

    initial begin
        int          n;
        logic [31:0] w;
        logic [31:0] r;
        logic [31:0] rp;

        seed  = 32'h6a645ecd;
        n     = 0;
        reset = 1'b1;
        fetch = '0;
        repeat (resetCycles) @(posedge clk);
        #2;
        reset = 1'b0;

        for (int i = 0; i < 26; i++) begin
            w = {`OPC_SPECIAL, 5'(i + 1), 5'(3 * i + 2), 5'(31 - i), 5'(i + 5),
                 specialFuncts[i*6 +: 6]};
            driveFetch(makeFetch(1'b1, w, 32'h9000_0100 + 32'(4 * n), n[0]));
            n++;
        end
        for (int i = 0; i < 4; i++) begin
            w = {`OPC_REGIMM, 5'(i + 9), regimmCodes[i*5 +: 5], 16'hfff0 + 16'(i)};
            driveFetch(makeFetch(1'b1, w, 32'h9000_0100 + 32'(4 * n), n[0]));
            n++;
        end
        for (int op = 2; op < 16; op++) begin
            w = {6'(op), 5'(op + 3), 5'(2 * op), op[0] ? 16'h8123 : 16'h0123 + 16'(op)};
            driveFetch(makeFetch(1'b1, w, 32'h9000_0100 + 32'(4 * n), n[0]));
            n++;
        end
        driveFetch(makeFetch(1'b1, 32'h0, 32'h9000_0100 + 32'(4 * n), 1'b0));
        for (int i = 0; i < 7; i++) begin
            driveFetch(makeFetch(1'b1, illegalWords[i*32 +: 32], 32'h9000_0200 + 32'(4 * i),
                                 1'b0));
        end

        // Most words get a kept opcode, and SPECIAL and REGIMM often a kept code.
        for (int i = 0; i < randomCount; i++) begin
            r  = $random(seed);
            w  = $random(seed);
            rp = $random(seed);
            if (r[1:0] != 2'b00)
                w[31:26] = {2'b00, r[5:2]};
            if (w[31:26] == `OPC_SPECIAL && r[6])
                w[5:0] = specialFuncts[(r[11:7] % 26)*6 +: 6];
            if (w[31:26] == `OPC_REGIMM && r[12])
                w[20:16] = {r[13], 3'b000, r[14]};
            driveFetch(makeFetch(r[17:15] != 3'd0, w, {rp[31:2], 2'b00}, r[18]));
        end

        repeat (drainCycles) driveFetch(makeFetch(1'b0, 32'h0, 32'h0, 1'b0));
        wait (expQ.size() == 0);
        @(posedge clk);
        $display("Checks done: %0d values compared, %0d errors", checkCount, errorCount);
        if (errorCount == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// File: files.f
+incdir+include
logic/decodePkg.sv
logic/fieldStage.sv
logic/classStage.sv
logic/uopStage.sv
logic/decodeTop.sv
bench/decodeTb.sv

// File: include/decode_macros.svh
`ifndef DECODE_MACROS_SVH
`define DECODE_MACROS_SVH

`define DECODE_XLEN 32
`define REG_ADDR_W  6

// HI and LO sit just above the architectural registers.
`define REG_LINK 6'd31
`define REG_HI   6'd32
`define REG_LO   6'd33

`define OPC_SPECIAL 6'h00
`define OPC_REGIMM  6'h01
`define OPC_J       6'h02
`define OPC_JAL     6'h03
`define OPC_BEQ     6'h04
`define OPC_BNE     6'h05
`define OPC_BLEZ    6'h06
`define OPC_BGTZ    6'h07
`define OPC_ADDI    6'h08
`define OPC_ADDIU   6'h09
`define OPC_SLTI    6'h0a
`define OPC_SLTIU   6'h0b
`define OPC_ANDI    6'h0c
`define OPC_ORI     6'h0d
`define OPC_XORI    6'h0e
`define OPC_LUI     6'h0f

`define FUNCT_SLL   6'h00
`define FUNCT_SRL   6'h02
`define FUNCT_SRA   6'h03
`define FUNCT_SLLV  6'h04
`define FUNCT_SRLV  6'h06
`define FUNCT_SRAV  6'h07
`define FUNCT_JR    6'h08
`define FUNCT_JALR  6'h09
`define FUNCT_MFHI  6'h10
`define FUNCT_MTHI  6'h11
`define FUNCT_MFLO  6'h12
`define FUNCT_MTLO  6'h13
`define FUNCT_MULT  6'h18
`define FUNCT_MULTU 6'h19
`define FUNCT_DIV   6'h1a
`define FUNCT_DIVU  6'h1b
`define FUNCT_ADD   6'h20
`define FUNCT_ADDU  6'h21
`define FUNCT_SUB   6'h22
`define FUNCT_SUBU  6'h23
`define FUNCT_AND   6'h24
`define FUNCT_OR    6'h25
`define FUNCT_XOR   6'h26
`define FUNCT_NOR   6'h27
`define FUNCT_SLT   6'h2a
`define FUNCT_SLTU  6'h2b

`define RT_BLTZ   5'h00
`define RT_BGEZ   5'h01
`define RT_BLTZAL 5'h10
`define RT_BGEZAL 5'h11

`endif

// File: logic/classStage.sv
`timescale 1ns/1ps
`include "decode_macros.svh"

module classStage (
    input  logic                    clk,
    input  logic                    reset,
    input  decodePkg::fieldBundle_t fields,
    output decodePkg::classBundle_t classified
);
    import decodePkg::*;

    logic       allZero;
    instClass_t clsNext;

    // Every R-format field zero means the whole word is zero, which is the NOP.
    assign allZero = (fields.opcode == `OPC_SPECIAL) && (fields.funct == `FUNCT_SLL) &&
                     (fields.rsAddr == '0) && (fields.rtAddr == '0) &&
                     (fields.rdAddr == '0) && (fields.shamtImm == '0);

    always_comb begin
        clsNext = CLS_NONE;
        if (fields.valid && !allZero) begin
            case (fields.opcode)
                `OPC_SPECIAL: begin
                    case (fields.funct)
                        `FUNCT_ADD:   clsNext = CLS_ADD;
                        `FUNCT_ADDU:  clsNext = CLS_ADDU;
                        `FUNCT_SUB:   clsNext = CLS_SUB;
                        `FUNCT_SUBU:  clsNext = CLS_SUBU;
                        `FUNCT_SLT:   clsNext = CLS_SLT;
                        `FUNCT_SLTU:  clsNext = CLS_SLTU;
                        `FUNCT_AND:   clsNext = CLS_AND;
                        `FUNCT_OR:    clsNext = CLS_OR;
                        `FUNCT_XOR:   clsNext = CLS_XOR;
                        `FUNCT_NOR:   clsNext = CLS_NOR;
                        `FUNCT_SLL:   clsNext = CLS_SLL;
                        `FUNCT_SLLV:  clsNext = CLS_SLLV;
                        `FUNCT_SRA:   clsNext = CLS_SRA;
                        `FUNCT_SRAV:  clsNext = CLS_SRAV;
                        `FUNCT_SRL:   clsNext = CLS_SRL;
                        `FUNCT_SRLV:  clsNext = CLS_SRLV;
                        `FUNCT_JR:    clsNext = CLS_JR;
                        `FUNCT_JALR:  clsNext = CLS_JALR;
                        `FUNCT_MFHI:  clsNext = CLS_MFHI;
                        `FUNCT_MFLO:  clsNext = CLS_MFLO;
                        `FUNCT_MTHI:  clsNext = CLS_MTHI;
                        `FUNCT_MTLO:  clsNext = CLS_MTLO;
                        `FUNCT_MULT:  clsNext = CLS_MULT;
                        `FUNCT_MULTU: clsNext = CLS_MULTU;
                        `FUNCT_DIV:   clsNext = CLS_DIV;
                        `FUNCT_DIVU:  clsNext = CLS_DIVU;
                        default:      clsNext = CLS_NONE;
                    endcase
                end
                `OPC_REGIMM: begin
                    case (fields.rtCode)
                        `RT_BLTZ:   clsNext = CLS_BLTZ;
                        `RT_BGEZ:   clsNext = CLS_BGEZ;
                        `RT_BLTZAL: clsNext = CLS_BLTZAL;
                        `RT_BGEZAL: clsNext = CLS_BGEZAL;
                        default:    clsNext = CLS_NONE;
                    endcase
                end
                `OPC_J:     clsNext = CLS_J;
                `OPC_JAL:   clsNext = CLS_JAL;
                `OPC_BEQ:   clsNext = CLS_BEQ;
                `OPC_BNE:   clsNext = CLS_BNE;
                `OPC_BLEZ:  clsNext = CLS_BLEZ;
                `OPC_BGTZ:  clsNext = CLS_BGTZ;
                `OPC_ADDI:  clsNext = CLS_ADDI;
                `OPC_ADDIU: clsNext = CLS_ADDIU;
                `OPC_SLTI:  clsNext = CLS_SLTI;
                `OPC_SLTIU: clsNext = CLS_SLTIU;
                `OPC_ANDI:  clsNext = CLS_ANDI;
                `OPC_ORI:   clsNext = CLS_ORI;
                `OPC_XORI:  clsNext = CLS_XORI;
                `OPC_LUI:   clsNext = CLS_LUI;
                default:    clsNext = CLS_NONE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            classified <= '0;
        end else begin
            classified.fields <= fields;
            classified.cls    <= clsNext;
        end
    end

endmodule

// File: logic/decodePkg.sv
`include "decode_macros.svh"

package decodePkg;

    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rTypeFmt_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm16;
    } iTypeFmt_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] target26;
    } jTypeFmt_t;

    // One fetched word, seen through each of the MIPS encoding formats.
    typedef union packed {
        logic [`DECODE_XLEN-1:0] raw;
        rTypeFmt_t               rFmt;
        iTypeFmt_t               iFmt;
        jTypeFmt_t               jFmt;
    } instWord_t;

    typedef struct packed {
        logic                    valid;
        logic [`DECODE_XLEN-1:0] pc;
        instWord_t               inst;
        logic                    isDelaySlot;
    } fetchBundle_t;

    typedef struct packed {
        logic                    valid;
        logic [`DECODE_XLEN-1:0] pc;
        logic                    isDelaySlot;
        logic [5:0]              opcode;
        logic [5:0]              funct;
        logic [4:0]              rtCode;
        logic [`REG_ADDR_W-1:0]  rsAddr;
        logic [`REG_ADDR_W-1:0]  rtAddr;
        logic [`REG_ADDR_W-1:0]  rdAddr;
        logic [`DECODE_XLEN-1:0] immSigned;
        logic [`DECODE_XLEN-1:0] immZero;
        logic [`DECODE_XLEN-1:0] immUpper;
        logic [`DECODE_XLEN-1:0] shamtImm;
        logic [`DECODE_XLEN-1:0] branchOffset;
        logic [`DECODE_XLEN-1:0] jumpTarget;
    } fieldBundle_t;

    // Classes are grouped by kind, so a kind can be matched as a range.
    typedef enum logic [5:0] {
        CLS_NONE,
        CLS_ADD, CLS_ADDU, CLS_ADDI, CLS_ADDIU, CLS_SUB, CLS_SUBU,
        CLS_SLT, CLS_SLTU, CLS_SLTI, CLS_SLTIU,
        CLS_AND, CLS_ANDI, CLS_OR, CLS_ORI, CLS_XOR, CLS_XORI, CLS_NOR, CLS_LUI,
        CLS_SLL, CLS_SLLV, CLS_SRA, CLS_SRAV, CLS_SRL, CLS_SRLV,
        CLS_BEQ, CLS_BNE, CLS_BGEZ, CLS_BGTZ, CLS_BLEZ, CLS_BLTZ, CLS_BGEZAL, CLS_BLTZAL,
        CLS_J, CLS_JAL, CLS_JR, CLS_JALR,
        CLS_MFHI, CLS_MFLO, CLS_MTHI, CLS_MTLO,
        CLS_MULT, CLS_MULTU, CLS_DIV, CLS_DIVU
    } instClass_t;

    typedef struct packed {
        fieldBundle_t fields;
        instClass_t   cls;
    } classBundle_t;

    // The first 45 codes follow instClass_t one for one, and the HI halves of
    // multiply and divide take the class slot. The LO halves come last.
    typedef enum logic [6:0] {
        UOP_NONE,
        UOP_ADD, UOP_ADDU, UOP_ADDI, UOP_ADDIU, UOP_SUB, UOP_SUBU,
        UOP_SLT, UOP_SLTU, UOP_SLTI, UOP_SLTIU,
        UOP_AND, UOP_ANDI, UOP_OR, UOP_ORI, UOP_XOR, UOP_XORI, UOP_NOR, UOP_LUI,
        UOP_SLL, UOP_SLLV, UOP_SRA, UOP_SRAV, UOP_SRL, UOP_SRLV,
        UOP_BEQ, UOP_BNE, UOP_BGEZ, UOP_BGTZ, UOP_BLEZ, UOP_BLTZ, UOP_BGEZAL, UOP_BLTZAL,
        UOP_J, UOP_JAL, UOP_JR, UOP_JALR,
        UOP_MFHI, UOP_MFLO, UOP_MTHI, UOP_MTLO,
        UOP_MULTHI, UOP_MULTUHI, UOP_DIVHI, UOP_DIVUHI,
        UOP_MULTLO, UOP_MULTULO, UOP_DIVLO, UOP_DIVULO
    } uopCode_t;

    typedef enum logic {
        UNIT_ALU,
        UNIT_MDU
    } execUnit_t;

    typedef enum logic [2:0] {
        ALU_ARITH,
        ALU_LOGIC,
        ALU_SHIFT,
        ALU_BRANCH,
        ALU_MOVE
    } aluType_t;

    typedef enum logic [1:0] {
        BR_NONE,
        BR_COND,
        BR_JUMP,
        BR_JUMPREG
    } branchType_t;

    typedef struct packed {
        logic                    valid;
        uopCode_t                uopCode;
        execUnit_t               unit;
        aluType_t                aluType;
        logic [`REG_ADDR_W-1:0]  op0Addr;
        logic [`REG_ADDR_W-1:0]  op1Addr;
        logic [`REG_ADDR_W-1:0]  dstAddr;
        logic                    op0Read;
        logic                    op1Read;
        logic                    dstWrite;
        logic [`DECODE_XLEN-1:0] imm;
        branchType_t             branchType;
        logic [`DECODE_XLEN-1:0] branchAddr;
        logic [`DECODE_XLEN-1:0] pc;
        logic                    isDelaySlot;
    } microOp_t;

endpackage

// File: logic/decodeTop.sv
`timescale 1ns/1ps

module decodeTop (
    input  logic                    clk,
    input  logic                    reset,
    input  decodePkg::fetchBundle_t fetch,
    output decodePkg::microOp_t     uopPrimary,
    output decodePkg::microOp_t     uopSecondary
);
    import decodePkg::*;

    fieldBundle_t fields;
    classBundle_t classified;

    // Field extraction, classification and micro-op build, one cycle each.
    fieldStage u_fieldStage (
        .clk    (clk),
        .reset  (reset),
        .fetch  (fetch),
        .fields (fields)
    );

    classStage u_classStage (
        .clk        (clk),
        .reset      (reset),
        .fields     (fields),
        .classified (classified)
    );

    uopStage u_uopStage (
        .clk          (clk),
        .reset        (reset),
        .classified   (classified),
        .uopPrimary   (uopPrimary),
        .uopSecondary (uopSecondary)
    );

endmodule

// File: logic/fieldStage.sv
`timescale 1ns/1ps
`include "decode_macros.svh"

module fieldStage (
    input  logic                    clk,
    input  logic                    reset,
    input  decodePkg::fetchBundle_t fetch,
    output decodePkg::fieldBundle_t fields
);
    import decodePkg::*;

    logic [15:0]  imm16;
    fieldBundle_t fieldsNext;

    assign imm16 = fetch.inst.iFmt.imm16;

    always_comb begin
        fieldsNext.valid       = fetch.valid;
        fieldsNext.pc          = fetch.pc;
        fieldsNext.isDelaySlot = fetch.isDelaySlot;

        fieldsNext.opcode = fetch.inst.rFmt.opcode;
        fieldsNext.funct  = fetch.inst.rFmt.funct;
        fieldsNext.rtCode = fetch.inst.iFmt.rt;

        fieldsNext.rsAddr = `REG_ADDR_W'(fetch.inst.rFmt.rs);
        fieldsNext.rtAddr = `REG_ADDR_W'(fetch.inst.rFmt.rt);
        fieldsNext.rdAddr = `REG_ADDR_W'(fetch.inst.rFmt.rd);

        fieldsNext.immSigned = {{(`DECODE_XLEN-16){imm16[15]}}, imm16};
        fieldsNext.immZero   = `DECODE_XLEN'(imm16);
        fieldsNext.immUpper  = {imm16, 16'b0};
        fieldsNext.shamtImm  = `DECODE_XLEN'(fetch.inst.rFmt.shamt);

        // Branch offsets are word counts relative to the delay slot.
        fieldsNext.branchOffset = {{(`DECODE_XLEN-18){imm16[15]}}, imm16, 2'b00};

        // Jumps stay inside the current 256 MB region.
        fieldsNext.jumpTarget = {fetch.pc[`DECODE_XLEN-1 -: 4],
                                 fetch.inst.jFmt.target26,
                                 2'b00};
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            fields <= '0;
        end else begin
            fields <= fieldsNext;
        end
    end

endmodule

// File: logic/uopStage.sv
`timescale 1ns/1ps
`include "decode_macros.svh"

module uopStage (
    input  logic                    clk,
    input  logic                    reset,
    input  decodePkg::classBundle_t classified,
    output decodePkg::microOp_t     uopPrimary,
    output decodePkg::microOp_t     uopSecondary
);
    import decodePkg::*;

    fieldBundle_t f;
    instClass_t   cls;
    microOp_t     primNext;
    microOp_t     secNext;

    assign f   = classified.fields;
    assign cls = classified.cls;

    always_comb begin
        primNext             = '0;
        primNext.pc          = f.pc;
        primNext.isDelaySlot = f.isDelaySlot;
        primNext.valid       = (cls != CLS_NONE);
        primNext.uopCode     = uopCode_t'({1'b0, cls});

        case (cls) inside
            [CLS_AND:CLS_LUI]:    primNext.aluType = ALU_LOGIC;
            [CLS_SLL:CLS_SRLV]:   primNext.aluType = ALU_SHIFT;
            [CLS_BEQ:CLS_JALR]:   primNext.aluType = ALU_BRANCH;
            [CLS_MFHI:CLS_MTLO]:  primNext.aluType = ALU_MOVE;
            default:              primNext.aluType = ALU_ARITH;
        endcase

        case (cls)
            CLS_ADDI, CLS_ADDIU, CLS_SLTI, CLS_SLTIU: primNext.imm = f.immSigned;
            CLS_ANDI, CLS_ORI, CLS_XORI:             primNext.imm = f.immZero;
            CLS_LUI:                                 primNext.imm = f.immUpper;
            CLS_SLL, CLS_SRA, CLS_SRL:               primNext.imm = f.shamtImm;
            default:                                 primNext.imm = '0;
        endcase

        case (cls) inside
            [CLS_BEQ:CLS_BLTZAL]: begin
                primNext.branchType = BR_COND;
                primNext.branchAddr = f.branchOffset;
            end
            CLS_J, CLS_JAL: begin
                primNext.branchType = BR_JUMP;
                primNext.branchAddr = f.jumpTarget;
            end
            CLS_JR, CLS_JALR: primNext.branchType = BR_JUMPREG;
            default:          primNext.branchType = BR_NONE;
        endcase

        case (cls)
            CLS_ADD, CLS_ADDU, CLS_SUB, CLS_SUBU, CLS_SLT, CLS_SLTU,
            CLS_AND, CLS_OR, CLS_XOR, CLS_NOR: begin
                primNext.op0Addr  = f.rsAddr;
                primNext.op1Addr  = f.rtAddr;
                primNext.dstAddr  = f.rdAddr;
                primNext.op0Read  = 1'b1;
                primNext.op1Read  = 1'b1;
                primNext.dstWrite = 1'b1;
            end
            CLS_ADDI, CLS_ADDIU, CLS_SLTI, CLS_SLTIU,
            CLS_ANDI, CLS_ORI, CLS_XORI, CLS_LUI: begin
                primNext.op0Addr  = f.rsAddr;
                primNext.dstAddr  = f.rtAddr;
                primNext.op0Read  = 1'b1;
                primNext.dstWrite = 1'b1;
            end
            // Variable shifts take the value from rt and the amount from rs.
            CLS_SLLV, CLS_SRAV, CLS_SRLV: begin
                primNext.op0Addr  = f.rtAddr;
                primNext.op1Addr  = f.rsAddr;
                primNext.dstAddr  = f.rdAddr;
                primNext.op0Read  = 1'b1;
                primNext.op1Read  = 1'b1;
                primNext.dstWrite = 1'b1;
            end
            CLS_SLL, CLS_SRA, CLS_SRL: begin
                primNext.op0Addr  = f.rtAddr;
                primNext.dstAddr  = f.rdAddr;
                primNext.op0Read  = 1'b1;
                primNext.dstWrite = 1'b1;
            end
            CLS_BEQ, CLS_BNE: begin
                primNext.op0Addr = f.rsAddr;
                primNext.op1Addr = f.rtAddr;
                primNext.op0Read = 1'b1;
                primNext.op1Read = 1'b1;
            end
            CLS_BGEZ, CLS_BGTZ, CLS_BLEZ, CLS_BLTZ, CLS_JR: begin
                primNext.op0Addr = f.rsAddr;
                primNext.op0Read = 1'b1;
            end
            CLS_BGEZAL, CLS_BLTZAL, CLS_JALR: begin
                primNext.op0Addr  = f.rsAddr;
                primNext.dstAddr  = (cls == CLS_JALR) ? f.rdAddr : `REG_LINK;
                primNext.op0Read  = 1'b1;
                primNext.dstWrite = 1'b1;
            end
            CLS_JAL: begin
                primNext.dstAddr  = `REG_LINK;
                primNext.dstWrite = 1'b1;
            end
            CLS_MFHI, CLS_MFLO: begin
                primNext.op0Addr  = (cls == CLS_MFHI) ? `REG_HI : `REG_LO;
                primNext.dstAddr  = f.rdAddr;
                primNext.op0Read  = 1'b1;
                primNext.dstWrite = 1'b1;
            end
            CLS_MTHI, CLS_MTLO: begin
                primNext.op0Addr  = f.rsAddr;
                primNext.dstAddr  = (cls == CLS_MTHI) ? `REG_HI : `REG_LO;
                primNext.op0Read  = 1'b1;
                primNext.dstWrite = 1'b1;
            end
            CLS_MULT, CLS_MULTU, CLS_DIV, CLS_DIVU: begin
                primNext.unit     = UNIT_MDU;
                primNext.op0Addr  = f.rsAddr;
                primNext.op1Addr  = f.rtAddr;
                primNext.dstAddr  = `REG_HI;
                primNext.op0Read  = 1'b1;
                primNext.op1Read  = 1'b1;
                primNext.dstWrite = 1'b1;
            end
            default: begin
            end
        endcase

        // The second micro-op is the LO half of a multiply or divide.
        secNext             = '0;
        secNext.pc          = f.pc;
        secNext.isDelaySlot = f.isDelaySlot;
        if (primNext.unit == UNIT_MDU) begin
            secNext         = primNext;
            secNext.dstAddr = `REG_LO;
            case (cls)
                CLS_MULT:  secNext.uopCode = UOP_MULTLO;
                CLS_MULTU: secNext.uopCode = UOP_MULTULO;
                CLS_DIV:   secNext.uopCode = UOP_DIVLO;
                default:   secNext.uopCode = UOP_DIVULO;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            uopPrimary   <= '0;
            uopSecondary <= '0;
        end else begin
            uopPrimary   <= primNext;
            uopSecondary <= secNext;
        end
    end

endmodule
